// File: design/rx01_top.sv
`timescale 1ns/10ps
`include "rx_defines.svh"

module rx01_top (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic [1:0]            wb_adr_i,
   input  logic [15:0]           wb_dat_i,
   input  logic [1:0]            wb_sel_i,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   output logic [15:0]           wb_dat_o,
   output logic                  wb_ack_o,
   output logic                  irq_o,
   input  logic                  iack_i,
   input  logic [`RX_BLK_AW-1:0] start_offset_i,  // image base
   input  logic                  sto_ack_i,
   input  logic                  sto_done_i,
   input  logic                  sto_error_i,
   output logic                  sto_req_o,
   output logic                  sto_start_o,
   output logic                  sto_write_o,
   output logic [`RX_BLK_AW-1:0] sto_addr_o,
   input  logic [`RX_BUF_AW-1:0] sto_buf_adr_i,
   input  logic [7:0]            sto_buf_dat_i,
   input  logic                  sto_buf_we_i,
   output logic [7:0]            sto_buf_dat_o
);

   logic ide;
   logic done_evt;
   logic go_evt;

   rx_host_if host ();
   rx_buf_if  sbuf ();

   // ********************
   // bus, controller, buffer, interrupt
   // ********************
   rx_bus_regs i_bus_regs (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .host     (host.bus)
   );

   rx_cmd_ctrl i_cmd_ctrl (
      .wb_clk_i       (wb_clk_i),
      .wb_rst_i       (wb_rst_i),
      .host           (host.ctrl),
      .sbuf           (sbuf.ctrl),
      .start_offset_i (start_offset_i),
      .sto_ack_i      (sto_ack_i),
      .sto_done_i     (sto_done_i),
      .sto_error_i    (sto_error_i),
      .sto_req_o      (sto_req_o),
      .sto_start_o    (sto_start_o),
      .sto_write_o    (sto_write_o),
      .sto_addr_o     (sto_addr_o),
      .ide_o          (ide),
      .done_evt_o     (done_evt),
      .go_evt_o       (go_evt)
   );

   rx_sector_buf i_sector_buf (
      .wb_clk_i      (wb_clk_i),
      .sbuf          (sbuf.ram),
      .sto_buf_adr_i (sto_buf_adr_i),
      .sto_buf_dat_i (sto_buf_dat_i),
      .sto_buf_we_i  (sto_buf_we_i),
      .sto_buf_dat_o (sto_buf_dat_o)
   );

   rx_irq i_irq (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .ide_i      (ide),
      .done_evt_i (done_evt),
      .go_evt_i   (go_evt),
      .iack_i     (iack_i),
      .irq_o      (irq_o)
   );

endmodule

// File: design/rx_bus_regs.sv
`timescale 1ns/10ps

module rx_bus_regs (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [1:0]  wb_adr_i,   // bit 1 picks dxcsr / dxbuf
   input  logic [15:0] wb_dat_i,
   input  logic [1:0]  wb_sel_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   output logic [15:0] wb_dat_o,
   output logic        wb_ack_o,
   rx_host_if.bus      host
);

   logic reply;   // first cycle of a bus cycle
   logic wr_req;
   logic rd_req;
   logic sel_buf; // dxbuf addressed

   assign reply   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign wr_req  = reply & wb_we_i;
   assign rd_req  = reply & ~wb_we_i;
   assign sel_buf = wb_adr_i[1];

   // ********************
   // strobes toward the controller
   // ********************
   assign host.csr_wr    = wr_req & ~sel_buf & wb_sel_i[0];
   assign host.csr_hi_wr = wr_req & ~sel_buf & wb_sel_i[1];  // soft reset lives here
   assign host.buf_wr    = wr_req & sel_buf & wb_sel_i[0];
   assign host.csr_rd    = rd_req & ~sel_buf;
   assign host.buf_rd    = rd_req & sel_buf;
   assign host.wdata     = wb_dat_i;

   // ack one cycle after strobe, never back to back
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= reply;
      end
   end

   // read data latched on the ack edge
   always_ff @(posedge wb_clk_i) begin
      if (rd_req) begin
         wb_dat_o <= sel_buf ? host.buf_rdata : host.csr_rdata;
      end
   end

   a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_ack_o |=> !wb_ack_o);

endmodule

// File: design/rx_cmd_ctrl.sv
`timescale 1ns/10ps
`include "rx_defines.svh"

module rx_cmd_ctrl (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   rx_host_if.ctrl               host,
   rx_buf_if.ctrl                sbuf,
   input  logic [`RX_BLK_AW-1:0] start_offset_i,
   input  logic                  sto_ack_i,
   input  logic                  sto_done_i,
   input  logic                  sto_error_i,
   output logic                  sto_req_o,
   output logic                  sto_start_o,
   output logic                  sto_write_o,
   output logic [`RX_BLK_AW-1:0] sto_addr_o,
   output logic                  ide_o,
   output logic                  done_evt_o,   // set interrupt trigger
   output logic                  go_evt_o      // clear interrupt trigger
);

   rx_pkg::rx_cmd_e      cmd;
   rx_pkg::rx_cmd_e      fn;         // function code on the bus
   rx_pkg::rx_io_state_e io_state;
   logic                 start;      // command active
   logic                 done;
   logic                 done_seen;  // first dxcsr read after reset taken
   logic                 drq;
   logic                 err;
   logic                 drv;
   logic [6:0]           cyl;
   logic [4:0]           sec;
   logic                 sec_phase;  // next dxbuf write is the sector
   logic                 trk_phase;  // next dxbuf write is the track
   logic                 io_phase;   // chs complete, storage step
   logic [`RX_BUF_AW-1:0] ptr;
   logic                 soft_rst;
   logic                 go_ok;
   logic                 buf_cmd;
   logic                 buf_step;   // one fill/empty byte moved
   logic                 sec_wr;
   logic                 trk_wr;
   logic                 chs_bad;
   logic                 fin;        // command completes this edge

   assign fn       = rx_pkg::rx_cmd_e'(host.wdata[`RX_CSR_FN_LSB +: 3]);
   assign soft_rst = host.csr_hi_wr & host.wdata[`RX_CSR_INIT];
   assign go_ok    = host.csr_wr & host.wdata[`RX_CSR_GO] & ~start;
   assign buf_cmd  = (cmd == rx_pkg::CMD_FILL) || (cmd == rx_pkg::CMD_EMPTY);
   assign buf_step = drq && ((host.buf_wr && cmd == rx_pkg::CMD_FILL) ||
                             (host.buf_rd && cmd == rx_pkg::CMD_EMPTY));
   assign sec_wr   = host.buf_wr & start & sec_phase;
   assign trk_wr   = host.buf_wr & start & trk_phase;
   assign chs_bad  = (cyl > `RX_MAX_CYL) || (sec > `RX_MAX_SEC) || (sec == 5'd0);

   // block address, drive/cyl/sec side by side
   assign sto_addr_o = start_offset_i + {14'd0, drv, cyl, sec};

   always_comb begin
      case (cmd)
         rx_pkg::CMD_FILL, rx_pkg::CMD_EMPTY: fin = buf_step & (&ptr);  // last byte
         rx_pkg::CMD_WRSEC, rx_pkg::CMD_RDSEC:
            fin = (io_phase && io_state == rx_pkg::IO_START && chs_bad) ||
                  (io_state == rx_pkg::IO_DONE);
         default: fin = 1'b1;  // status, error reg, invalid
      endcase
      fin = fin & start;
   end

   // ********************
   // register read paths
   // ********************
   always_comb begin
      host.csr_rdata = '0;
      host.csr_rdata[`RX_CSR_ERR]  = err;
      host.csr_rdata[`RX_CSR_DRQ]  = drq;
      host.csr_rdata[`RX_CSR_IE]   = ide_o;
      host.csr_rdata[`RX_CSR_DONE] = done | ~done_seen;  // done shown right after reset
      host.csr_rdata[`RX_CSR_DRV]  = drv;
   end

   always_comb begin
      host.buf_rdata = '0;
      case (cmd)
         rx_pkg::CMD_EMPTY: host.buf_rdata[7:0] = sbuf.rdata;
         rx_pkg::CMD_STATUS: begin
            host.buf_rdata[`RX_ES_INIT] = 1'b1;
            host.buf_rdata[`RX_ES_IDLE] = ~sto_req_o;
         end
         default: ;  // error register reads zero
      endcase
   end

   assign sbuf.addr  = ptr;
   assign sbuf.wdata = host.wdata[7:0];
   assign sbuf.we    = buf_step & (cmd == rx_pkg::CMD_FILL);

   // ********************
   // command sequencing
   // ********************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         cmd         <= rx_pkg::CMD_BAD;
         io_state    <= rx_pkg::IO_START;
         start       <= 1'b0;
         done        <= 1'b0;
         done_seen   <= 1'b0;
         drq         <= 1'b0;
         err         <= 1'b0;
         drv         <= 1'b0;
         ide_o       <= 1'b0;
         sec_phase   <= 1'b0;
         trk_phase   <= 1'b0;
         io_phase    <= 1'b0;
         sto_req_o   <= 1'b0;
         sto_start_o <= 1'b0;
         sto_write_o <= 1'b0;
         done_evt_o  <= 1'b0;
         go_evt_o    <= 1'b0;
      end else if (soft_rst) begin  // dxcsr bit 14
         cmd         <= rx_pkg::CMD_BAD;
         io_state    <= rx_pkg::IO_START;
         start       <= 1'b0;
         done        <= 1'b0;
         done_seen   <= 1'b0;
         drq         <= 1'b0;
         err         <= 1'b0;
         drv         <= 1'b0;
         ide_o       <= 1'b0;
         sec_phase   <= 1'b0;
         trk_phase   <= 1'b0;
         io_phase    <= 1'b0;
         sto_req_o   <= 1'b0;
         sto_start_o <= 1'b0;
         sto_write_o <= 1'b0;
         done_evt_o  <= 1'b0;
         go_evt_o    <= 1'b0;
      end else begin
         done_evt_o <= 1'b0;
         go_evt_o   <= 1'b0;
         if (host.csr_wr) begin
            ide_o <= host.wdata[`RX_CSR_IE];  // ie writable any time
         end
         if (go_ok) begin
            cmd       <= fn;
            drv       <= host.wdata[`RX_CSR_DRV];
            start     <= 1'b1;
            done      <= 1'b0;
            done_seen <= 1'b1;
            drq       <= 1'b0;
            err       <= 1'b0;
            sec_phase <= (fn == rx_pkg::CMD_WRSEC) || (fn == rx_pkg::CMD_RDSEC);
            trk_phase <= 1'b0;
            io_phase  <= 1'b0;
            io_state  <= rx_pkg::IO_START;
            go_evt_o  <= 1'b1;
         end else if (host.csr_wr && host.wdata[`RX_CSR_IE] && done) begin
            done_evt_o <= 1'b1;  // ie set on a finished command
         end
         if (host.csr_rd && !done_seen) begin
            done_seen <= 1'b1;
            done      <= 1'b1;
         end
         if (sec_wr) begin
            sec_phase <= 1'b0;
            trk_phase <= 1'b1;
         end
         if (trk_wr) begin
            trk_phase <= 1'b0;
            io_phase  <= 1'b1;
            drq       <= 1'b0;
         end
         if (start) begin
            case (cmd)
               rx_pkg::CMD_FILL, rx_pkg::CMD_EMPTY: begin
                  if (!drq) drq <= 1'b1;
               end
               rx_pkg::CMD_WRSEC, rx_pkg::CMD_RDSEC: begin
                  if (sec_phase) drq <= 1'b1;  // ask for sector number
                  if (io_phase) begin
                     case (io_state)
                        rx_pkg::IO_START: begin
                           if (chs_bad) begin
                              err <= 1'b1;
                           end else begin
                              sto_req_o <= 1'b1;
                              if (sto_req_o && sto_ack_i) begin
                                 sto_start_o <= 1'b1;
                                 sto_write_o <= (cmd == rx_pkg::CMD_WRSEC);
                                 io_state    <= rx_pkg::IO_WAIT;
                              end
                           end
                        end
                        rx_pkg::IO_WAIT: begin
                           if (sto_done_i) begin
                              err      <= sto_error_i;
                              io_state <= rx_pkg::IO_DONE;
                           end
                        end
                        rx_pkg::IO_DONE: begin  // release storage
                           sto_req_o   <= 1'b0;
                           sto_start_o <= 1'b0;
                           sto_write_o <= 1'b0;
                           io_state    <= rx_pkg::IO_START;
                        end
                        default: io_state <= rx_pkg::IO_START;
                     endcase
                  end
               end
               rx_pkg::CMD_STATUS, rx_pkg::CMD_ERRREG: ;
               default: err <= 1'b1;  // codes 100 and 110
            endcase
         end
         if (fin) begin
            done       <= 1'b1;
            start      <= 1'b0;
            drq        <= 1'b0;
            io_phase   <= 1'b0;
            done_evt_o <= 1'b1;
         end
      end
   end

   // chs and buffer pointer, no reset needed
   always_ff @(posedge wb_clk_i) begin
      if (sec_wr) sec <= host.wdata[4:0];
      if (trk_wr) cyl <= host.wdata[6:0];
      if (start && buf_cmd && !drq) begin
         ptr <= '0;
      end else if (buf_step) begin
         ptr <= ptr + 1'b1;
      end
   end

   a_start_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      sto_start_o |-> sto_req_o);
   a_drq_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(drq && done));
   a_chs_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(sto_req_o) |-> $past(!chs_bad));

endmodule

// File: design/rx_defines.svh
`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

// sector buffer geometry
`define RX_BUF_WORDS  128      // bytes per sector
`define RX_BUF_AW     7        // buffer address width

// legal chs range
`define RX_MAX_CYL    76       // cylinders 0..76
`define RX_MAX_SEC    26       // sectors 1..26
`define RX_BLK_AW     27       // block address and start offset width

// dxcsr bit positions
`define RX_CSR_GO     0
`define RX_CSR_FN_LSB 1        // function code, 3 bits
`define RX_CSR_DRV    4
`define RX_CSR_DONE   5
`define RX_CSR_IE     6
`define RX_CSR_DRQ    7
`define RX_CSR_INIT   14       // soft reset, write only
`define RX_CSR_ERR    15

// rxes bits
`define RX_ES_INIT    2        // init done, always one
`define RX_ES_IDLE    7        // storage idle

`endif

// File: design/rx_ifs.sv
`timescale 1ns/10ps
`include "rx_defines.svh"

// register strobes and read data between bus block and controller
interface rx_host_if;
   logic        csr_wr;     // dxcsr low byte write
   logic        csr_hi_wr;  // dxcsr high byte write
   logic        csr_rd;     // dxcsr read
   logic        buf_wr;     // dxbuf write
   logic        buf_rd;     // dxbuf read
   logic [15:0] wdata;
   logic [15:0] csr_rdata;
   logic [15:0] buf_rdata;

   modport bus  (output csr_wr, csr_hi_wr, csr_rd, buf_wr, buf_rd, wdata,
                 input  csr_rdata, buf_rdata);
   modport ctrl (input  csr_wr, csr_hi_wr, csr_rd, buf_wr, buf_rd, wdata,
                 output csr_rdata, buf_rdata);
endinterface

// controller side of the sector buffer
interface rx_buf_if;
   logic [`RX_BUF_AW-1:0] addr;
   logic [7:0]            wdata;
   logic                  we;
   logic [7:0]            rdata;  // async read

   modport ctrl (output addr, wdata, we, input rdata);
   modport ram  (input addr, wdata, we, output rdata);
endinterface

// File: design/rx_irq.sv
`timescale 1ns/10ps

module rx_irq (
   input  logic wb_clk_i,
   input  logic wb_rst_i,
   input  logic ide_i,
   input  logic done_evt_i,
   input  logic go_evt_i,
   input  logic iack_i,
   output logic irq_o
);

   rx_pkg::rx_irq_state_e state;
   logic                  trigger;  // pending request

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state   <= rx_pkg::IRQ_IDLE;
         irq_o   <= 1'b0;
         trigger <= 1'b1;  // set out of reset
      end else begin
         case (state)
            rx_pkg::IRQ_IDLE: begin
               if (ide_i && trigger) begin
                  state <= rx_pkg::IRQ_REQ;
                  irq_o <= 1'b1;
               end else begin
                  irq_o <= 1'b0;
               end
            end
            rx_pkg::IRQ_REQ: begin
               if (!ide_i) begin       // ie dropped, withdraw
                  state <= rx_pkg::IRQ_IDLE;
                  irq_o <= 1'b0;
               end else if (iack_i) begin
                  irq_o   <= 1'b0;
                  trigger <= 1'b0;
                  state   <= rx_pkg::IRQ_WAIT;
               end
            end
            rx_pkg::IRQ_WAIT: if (!iack_i) state <= rx_pkg::IRQ_IDLE;  // ack released
            default: state <= rx_pkg::IRQ_IDLE;
         endcase
         // controller events win over the ack
         if (done_evt_i) begin
            trigger <= 1'b1;
         end else if (go_evt_i) begin
            trigger <= 1'b0;
         end
      end
   end

   a_irq_ie: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(irq_o) |-> $past(ide_i));

endmodule

// File: design/rx_pkg.sv
package rx_pkg;

   // dxcsr function codes
   typedef enum logic [2:0] {
      CMD_FILL    = 3'b000,  // host -> buffer
      CMD_EMPTY   = 3'b001,  // buffer -> host
      CMD_WRSEC   = 3'b010,  // buffer -> storage
      CMD_RDSEC   = 3'b011,  // storage -> buffer
      CMD_BAD     = 3'b100,  // invalid
      CMD_STATUS  = 3'b101,  // read rxes
      CMD_BAD_DEL = 3'b110,  // deleted-data write, unsupported
      CMD_ERRREG  = 3'b111   // read error register
   } rx_cmd_e;

   // storage transfer phases
   typedef enum logic [1:0] {
      IO_START = 2'd0,  // chs check, request storage
      IO_WAIT  = 2'd1,  // transfer running
      IO_DONE  = 2'd2   // release storage
   } rx_io_state_e;

   // interrupt handshake
   typedef enum logic [1:0] {
      IRQ_IDLE = 2'd0,
      IRQ_REQ  = 2'd1,
      IRQ_WAIT = 2'd2
   } rx_irq_state_e;

endpackage

// File: design/rx_sector_buf.sv
`timescale 1ns/10ps
`include "rx_defines.svh"

module rx_sector_buf (
   input  logic                  wb_clk_i,
   rx_buf_if.ram                 sbuf,
   input  logic [`RX_BUF_AW-1:0] sto_buf_adr_i,
   input  logic [7:0]            sto_buf_dat_i,
   input  logic                  sto_buf_we_i,
   output logic [7:0]            sto_buf_dat_o
);

   logic [7:0] mem [0:`RX_BUF_WORDS-1];  // one sector

   // both ports write on the clock
   always_ff @(posedge wb_clk_i) begin
      if (sbuf.we) begin
         mem[sbuf.addr] <= sbuf.wdata;   // host fill
      end
      if (sto_buf_we_i) begin
         mem[sto_buf_adr_i] <= sto_buf_dat_i;  // storage read sector
      end
   end

   // async reads
   assign sbuf.rdata    = mem[sbuf.addr];
   assign sto_buf_dat_o = mem[sto_buf_adr_i];

   a_no_clash: assert property (@(posedge wb_clk_i)
      !(sbuf.we && sto_buf_we_i && (sbuf.addr == sto_buf_adr_i)));

endmodule

// File: project.f
+incdir+design
design/rx_pkg.sv
design/rx_ifs.sv
design/rx_bus_regs.sv
design/rx_cmd_ctrl.sv
design/rx_sector_buf.sv
design/rx_irq.sv
design/rx01_top.sv
tb/tb_rx01.sv

// File: tb/tb_rx01.sv
`timescale 1ns/10ps
`include "rx_defines.svh"

module tb_rx01;

   localparam logic [1:0] CSR_ADR = 2'b00;
   localparam logic [1:0] BUF_ADR = 2'b10;   // adr bit 1 picks dxbuf

   logic                  wb_clk_i;
   logic                  wb_rst_i;
   logic [1:0]            wb_adr_i;
   logic [15:0]           wb_dat_i;
   logic [1:0]            wb_sel_i;
   logic                  wb_cyc_i;
   logic                  wb_stb_i;
   logic                  wb_we_i;
   logic [15:0]           wb_dat_o;
   logic                  wb_ack_o;
   logic                  irq_o;
   logic                  iack_i;
   logic [`RX_BLK_AW-1:0] start_offset_i;
   logic                  sto_ack_i;
   logic                  sto_done_i;
   logic                  sto_error_i;
   logic                  sto_req_o;
   logic                  sto_start_o;
   logic                  sto_write_o;
   logic [`RX_BLK_AW-1:0] sto_addr_o;
   logic [`RX_BUF_AW-1:0] sto_buf_adr_i;
   logic [7:0]            sto_buf_dat_i;
   logic                  sto_buf_we_i;
   logic [7:0]            sto_buf_dat_o;

   logic [15:0]           lfsr;
   int                    errors = 0;
   int                    checks = 0;
   int                    err_mark = 0;
   int                    tests_ok = 0;
   int                    tests_bad = 0;
   logic                  chs_reject = 1'b0;   // storage must stay quiet
   logic [7:0]            wr_data  [0:`RX_BUF_WORDS-1];
   logic [7:0]            exp_data [0:`RX_BUF_WORDS-1];

   // storage model state
   logic [7:0]            disk [logic [`RX_BLK_AW+6:0]];  // {block, byte}
   int                    sto_st = 0;
   int                    sto_cnt = 0;
   int                    req_count = 0;
   logic                  sto_wr;
   logic [`RX_BLK_AW-1:0] sto_key;
   logic [`RX_BLK_AW-1:0] last_addr = '0;

   rx01_top i_dut (
      .wb_clk_i       (wb_clk_i),
      .wb_rst_i       (wb_rst_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_sel_i       (wb_sel_i),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .irq_o          (irq_o),
      .iack_i         (iack_i),
      .start_offset_i (start_offset_i),
      .sto_ack_i      (sto_ack_i),
      .sto_done_i     (sto_done_i),
      .sto_error_i    (sto_error_i),
      .sto_req_o      (sto_req_o),
      .sto_start_o    (sto_start_o),
      .sto_write_o    (sto_write_o),
      .sto_addr_o     (sto_addr_o),
      .sto_buf_adr_i  (sto_buf_adr_i),
      .sto_buf_dat_i  (sto_buf_dat_i),
      .sto_buf_we_i   (sto_buf_we_i),
      .sto_buf_dat_o  (sto_buf_dat_o)
   );

   always #20 wb_clk_i = ~wb_clk_i;   // 40 ns period

   a_no_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(chs_reject && sto_req_o))
      else begin
         $display("storage request raised for an illegal CHS at %0t", $time);
         errors++;
      end

   // ********************
   // helpers
   // ********************
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois, x^16+x^14+x^13+x^11+1
   endfunction

   task automatic next_byte(output logic [7:0] b);
      b = '0;
      for (int k = 0; k < 8; k++) begin
         b    = {b[6:0], lfsr[0]};   // one step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   function automatic logic [15:0] csr_word(input logic err, input logic drq,
                                            input logic ie, input logic done,
                                            input logic drv);
      logic [15:0] w;
      w = '0;
      w[`RX_CSR_ERR]  = err;
      w[`RX_CSR_DRQ]  = drq;
      w[`RX_CSR_IE]   = ie;
      w[`RX_CSR_DONE] = done;
      w[`RX_CSR_DRV]  = drv;
      return w;
   endfunction

   // start offset plus drive, cylinder, sector side by side
   function automatic logic [`RX_BLK_AW-1:0] blk_addr(input int drv, input int cyl,
                                                      input int sec);
      return start_offset_i + drv * 4096 + cyl * 32 + sec;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      checks++;
      assert (act === exp)
      else begin
         $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      if (errors == err_mark) begin
         $display("test %s: ok", name);
         tests_ok++;
      end else begin
         $display("test %s: %0d errors", name, errors - err_mark);
         tests_bad++;
      end
      err_mark = errors;
   endtask

   // ********************
   // bus access
   // ********************
   task automatic bus_cycle(input logic [1:0] adr, input logic we,
                            input logic [15:0] wdat, output logic [15:0] rdat);
      int n;
      wb_adr_i = adr;
      wb_we_i  = we;
      wb_dat_i = wdat;
      wb_sel_i = 2'b11;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      n = 0;
      do begin
         @(posedge wb_clk_i);
         #2;
         n++;
      end while (!wb_ack_o && n < 20);
      if (!wb_ack_o) begin
         $display("timeout: no Wishbone acknowledge at %0t", $time);
         errors++;
      end
      rdat     = wb_dat_o;
      wb_cyc_i = 1'b0;   // ack high now, next cycle ignored
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [1:0] adr, input logic [15:0] d);
      logic [15:0] unused;
      bus_cycle(adr, 1'b1, d, unused);
   endtask

   task automatic bus_read(input logic [1:0] adr, output logic [15:0] d);
      bus_cycle(adr, 1'b0, 16'h0000, d);
   endtask

   task automatic issue_cmd(input rx_pkg::rx_cmd_e c, input logic drv, input logic ie);
      logic [15:0] w;
      w = csr_word(1'b0, 1'b0, ie, 1'b0, drv);
      w[`RX_CSR_FN_LSB +: 3] = c;
      w[`RX_CSR_GO] = 1'b1;
      bus_write(CSR_ADR, w);
   endtask

   // poll dxcsr until a flag sets
   task automatic wait_csr(input int bitpos, input string what, output logic [15:0] csr);
      int n;
      n = 0;
      csr = '0;
      while (!csr[bitpos] && n < 1000) begin
         bus_read(CSR_ADR, csr);
         n++;
      end
      if (!csr[bitpos]) begin
         $display("timeout: %s never set in DXCSR at %0t", what, $time);
         errors++;
      end
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      while (irq_o !== level && n < 50) begin
         @(posedge wb_clk_i);
         #2;
         n++;
      end
      if (irq_o !== level) begin
         $display("timeout: irq_o did not go to %b at %0t", level, $time);
         errors++;
      end
   endtask

   task automatic fill_random();
      logic [15:0] csr;
      issue_cmd(rx_pkg::CMD_FILL, 1'b0, 1'b0);
      wait_csr(`RX_CSR_DRQ, "DRQ", csr);
      for (int i = 0; i < `RX_BUF_WORDS; i++) begin
         next_byte(wr_data[i]);
         bus_write(BUF_ADR, {8'h00, wr_data[i]});
      end
   endtask

   task automatic empty_check();
      logic [15:0] csr;
      logic [15:0] rd;
      issue_cmd(rx_pkg::CMD_EMPTY, 1'b0, 1'b0);
      wait_csr(`RX_CSR_DRQ, "DRQ", csr);
      for (int i = 0; i < `RX_BUF_WORDS; i++) begin
         bus_read(BUF_ADR, rd);
         check_val($sformatf("DXBUF[%0d]", i), {8'h00, exp_data[i]}, rd);
      end
   endtask

   task automatic sector_cmd(input rx_pkg::rx_cmd_e c, input logic drv, input int cyl,
                             input int sec, output logic [15:0] csr);
      issue_cmd(c, drv, 1'b0);
      wait_csr(`RX_CSR_DRQ, "DRQ", csr);
      bus_write(BUF_ADR, 16'(sec));   // sector first
      bus_write(BUF_ADR, 16'(cyl));   // then track
      wait_csr(`RX_CSR_DONE, "DONE", csr);
   endtask

   // ********************
   // storage model
   // ********************
   function automatic logic [7:0] disk_byte(input logic [`RX_BLK_AW+6:0] k);
      return disk.exists(k) ? disk[k] : 8'h00;   // unwritten blocks read zero
   endfunction

   always @(posedge wb_clk_i) begin
      #2;
      case (sto_st)
         0: if (sto_req_o && !sto_start_o) begin   // idle
               req_count++;
               last_addr = sto_addr_o;
               sto_cnt   = 0;
               sto_st    = 1;
            end
         1: begin   // grant after a few cycles
               sto_cnt++;
               if (sto_cnt == 3) begin
                  sto_ack_i = 1'b1;
                  sto_st    = 2;
               end
            end
         2: if (sto_start_o) begin
               sto_ack_i     = 1'b0;
               sto_key       = sto_addr_o;
               sto_wr        = sto_write_o;
               sto_cnt       = 0;
               sto_buf_adr_i = '0;
               if (!sto_wr) begin   // sector read fills the buffer
                  sto_buf_dat_i = disk_byte({sto_key, 7'd0});
                  sto_buf_we_i  = 1'b1;
               end
               sto_st = 3;
            end
         3: begin   // one byte per cycle
               if (sto_wr) disk[{sto_key, 7'(sto_cnt)}] = sto_buf_dat_o;
               sto_cnt++;
               if (sto_cnt == `RX_BUF_WORDS) begin
                  sto_buf_we_i = 1'b0;
                  sto_done_i   = 1'b1;
                  sto_st       = 4;
               end else begin
                  sto_buf_adr_i = 7'(sto_cnt);
                  if (!sto_wr) sto_buf_dat_i = disk_byte({sto_key, 7'(sto_cnt)});
               end
            end
         default: begin
               sto_done_i = 1'b0;   // single pulse
               sto_st     = 0;
            end
      endcase
   end

   // ********************
   // tests
   // ********************
   initial begin
      logic [15:0] csr;
      logic [15:0] rd;
      int          mark;
      wb_clk_i = 1'b0;
      wb_rst_i = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      iack_i   = 1'b0;
      start_offset_i = '0;
      sto_ack_i      = 1'b0;
      sto_done_i     = 1'b0;
      sto_error_i    = 1'b0;
      sto_buf_adr_i  = '0;
      sto_buf_dat_i  = '0;
      sto_buf_we_i   = 1'b0;
      lfsr = 16'd79;
      repeat (3) @(posedge wb_clk_i);
      #2;
      wb_rst_i = 1'b0;

      // status and error register
      bus_read(CSR_ADR, csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 0), csr);   // done right after reset
      issue_cmd(rx_pkg::CMD_STATUS, 1'b0, 1'b0);
      wait_csr(`RX_CSR_DONE, "DONE", csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 0), csr);
      bus_read(BUF_ADR, rd);
      check_val("RXES", (16'h1 << `RX_ES_INIT) | (16'h1 << `RX_ES_IDLE), rd);
      issue_cmd(rx_pkg::CMD_ERRREG, 1'b0, 1'b0);
      wait_csr(`RX_CSR_DONE, "DONE", csr);
      bus_read(BUF_ADR, rd);
      check_val("error register", 16'h0000, rd);
      end_test("status and error register");

      // codes 100 and 110
      issue_cmd(rx_pkg::CMD_BAD, 1'b0, 1'b0);
      wait_csr(`RX_CSR_DONE, "DONE", csr);
      check_val("DXCSR", csr_word(1, 0, 0, 1, 0), csr);
      issue_cmd(rx_pkg::CMD_BAD_DEL, 1'b0, 1'b0);
      wait_csr(`RX_CSR_DONE, "DONE", csr);
      check_val("DXCSR", csr_word(1, 0, 0, 1, 0), csr);
      end_test("invalid commands");

      // buffer round trip
      fill_random();
      bus_read(CSR_ADR, csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 0), csr);
      exp_data = wr_data;
      empty_check();
      bus_read(CSR_ADR, csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 0), csr);   // drq low after last byte
      end_test("buffer round trip");

      // sector write then read back
      start_offset_i = 27'h0123400;
      fill_random();
      exp_data = wr_data;
      mark = req_count;
      sector_cmd(rx_pkg::CMD_WRSEC, 1'b1, 40, 13, csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 1), csr);
      check_val("storage requests", mark + 1, req_count);
      check_val("sto_addr_o", blk_addr(1, 40, 13), last_addr);
      fill_random();   // overwrite with other bytes
      sector_cmd(rx_pkg::CMD_RDSEC, 1'b1, 40, 13, csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 1), csr);
      empty_check();
      sto_error_i = 1'b1;
      sector_cmd(rx_pkg::CMD_WRSEC, 1'b1, 41, 2, csr);
      check_val("DXCSR", csr_word(1, 0, 0, 1, 1), csr);
      sto_error_i = 1'b0;
      end_test("sector write and read");

      // illegal chs never reaches storage
      mark = req_count;
      chs_reject = 1'b1;
      sector_cmd(rx_pkg::CMD_WRSEC, 1'b0, 77, 5, csr);
      check_val("DXCSR", csr_word(1, 0, 0, 1, 0), csr);
      sector_cmd(rx_pkg::CMD_WRSEC, 1'b0, 10, 0, csr);
      check_val("DXCSR", csr_word(1, 0, 0, 1, 0), csr);
      sector_cmd(rx_pkg::CMD_RDSEC, 1'b0, 10, 27, csr);
      check_val("DXCSR", csr_word(1, 0, 0, 1, 0), csr);
      chs_reject = 1'b0;
      check_val("storage requests", mark, req_count);
      end_test("CHS rejection");

      // interrupts, then soft reset
      bus_write(CSR_ADR, csr_word(0, 0, 1, 0, 0));   // ie with done already set
      wait_irq(1'b1);
      check_val("irq_o", 1, irq_o);
      iack_i = 1'b1;
      wait_irq(1'b0);
      check_val("irq_o", 0, irq_o);
      iack_i = 1'b0;
      // trigger cleared by the ack, so only completion can raise irq now
      issue_cmd(rx_pkg::CMD_STATUS, 1'b0, 1'b1);
      check_val("irq_o", 0, irq_o);
      wait_csr(`RX_CSR_DONE, "DONE", csr);
      wait_irq(1'b1);
      check_val("irq_o", 1, irq_o);
      iack_i = 1'b1;
      wait_irq(1'b0);
      iack_i = 1'b0;
      issue_cmd(rx_pkg::CMD_BAD, 1'b0, 1'b1);
      wait_csr(`RX_CSR_DONE, "DONE", csr);
      check_val("DXCSR", csr_word(1, 0, 1, 1, 0), csr);
      bus_write(CSR_ADR, 16'h1 << `RX_CSR_INIT);
      wait_irq(1'b0);   // ie gone, request withdrawn
      bus_read(CSR_ADR, csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 0), csr);
      issue_cmd(rx_pkg::CMD_FILL, 1'b0, 1'b0);
      wait_csr(`RX_CSR_DRQ, "DRQ", csr);
      check_val("DXCSR", csr_word(0, 1, 0, 0, 0), csr);
      bus_write(CSR_ADR, 16'h1 << `RX_CSR_INIT);
      bus_read(CSR_ADR, csr);
      check_val("DXCSR", csr_word(0, 0, 0, 1, 0), csr);
      end_test("interrupts and soft reset");

      $display("tests ok %0d, tests with errors %0d, checks %0d, errors %0d",
               tests_ok, tests_bad, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
